// File: dzPkg.sv
// DZ11 shared definitions
// Register offsets, CSR and RBUF bit positions, line count and widths

`default_nettype none

package dzPkg;

   ////////////////////
   // Sizes

   // Eight serial lines behind one register block
   localparam int numLines = 8;
   // Line number width
   localparam int lineW = 3;
   // Register word width
   localparam int wordW = 16;
   // Word offset width
   localparam int addrW = 2;

   ////////////////////
   // Register offsets

   localparam logic [addrW-1:0] offCsr  = 2'd0;
   // Read only
   localparam logic [addrW-1:0] offRbuf = 2'd1;
   localparam logic [addrW-1:0] offTcr  = 2'd2;
   // Write only
   localparam logic [addrW-1:0] offTdr  = 2'd3;

   ////////////////////
   // CSR bits

   localparam int csrMaint   = 3;
   // Clear pulse, reads as zero
   localparam int csrClr     = 4;
   localparam int csrMse     = 5;
   localparam int csrRie     = 6;
   localparam int csrRdone   = 7;
   // TLINE sits in 10:8
   localparam int csrTlineLo = 8;
   localparam int csrTie     = 14;
   localparam int csrTrdy    = 15;

   // RBUF bits, data in 7:0 and line in 10:8
   localparam int rbufValid  = 15;
   localparam int rbufFrme   = 13;
   localparam int rbufLineLo = 8;

endpackage

`default_nettype wire

// File: dzRegs.sv
// DZ11 register block
// Decodes the word-offset bus, holds CSR and TCR, builds the read word
// and forms the level interrupt request

`timescale 1ns/1ps
`default_nettype none

module dzRegs
(
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          read,
   input  wire                          write,
   input  wire  [dzPkg::addrW-1:0]      addr,
   input  wire  [dzPkg::wordW-1:0]      wrData,
   input  wire                          trdy,
   input  wire  [dzPkg::lineW-1:0]      tline,
   input  wire  [dzPkg::wordW-1:0]      rbufWord,
   output logic [dzPkg::wordW-1:0]      rdData,
   output logic                         ack,
   output logic                         mse,
   output logic                         maint,
   output logic                         init,
   output logic [dzPkg::numLines-1:0]   lineEnable,
   output logic                         tdrWrite,
   output logic                         rbufRead,
   output logic                         intr
);

   logic                       csrRead;
   logic                       csrWrite;
   logic                       tcrRead;
   logic                       tcrWrite;
   logic                       rie;
   logic                       tie;
   logic                       rdone;
   logic [dzPkg::wordW-1:0]    csrWord;

   ////////////////////
   // Address decode

   assign csrRead  = read && (addr == dzPkg::offCsr);
   assign csrWrite = write && (addr == dzPkg::offCsr);
   assign rbufRead = read && (addr == dzPkg::offRbuf);
   assign tcrRead  = read && (addr == dzPkg::offTcr);
   assign tcrWrite = write && (addr == dzPkg::offTcr);
   assign tdrWrite = write && (addr == dzPkg::offTdr);

   // Same-cycle acknowledge for defined accesses only
   assign ack = csrRead | csrWrite | rbufRead | tcrRead | tcrWrite | tdrWrite;

   // Clear pulse, one cycle after CLR write
   // Also held through reset and the cycle after it
   always_ff @(posedge clk)
   begin
      if (rst)
         init <= 1'b1;
      else
         init <= csrWrite && wrData[dzPkg::csrClr];
   end

   ////////////////////
   // CSR and TCR

   always_ff @(posedge clk)
   begin
      if (rst || init)
      begin
         maint      <= 1'b0;
         mse        <= 1'b0;
         rie        <= 1'b0;
         tie        <= 1'b0;
         lineEnable <= '0;
      end
      else
      begin
         if (csrWrite)
         begin
            maint <= wrData[dzPkg::csrMaint];
            mse   <= wrData[dzPkg::csrMse];
            rie   <= wrData[dzPkg::csrRie];
            tie   <= wrData[dzPkg::csrTie];
         end
         // Only the line enables of TCR are kept
         if (tcrWrite)
            lineEnable <= wrData[dzPkg::numLines-1:0];
      end
   end

   // Receiver done straight from the RBUF valid bit
   assign rdone = rbufWord[dzPkg::rbufValid];

   // CSR read view with live status fields
   always_comb
   begin
      csrWord                                         = '0;
      csrWord[dzPkg::csrMaint]                        = maint;
      csrWord[dzPkg::csrMse]                          = mse;
      csrWord[dzPkg::csrRie]                          = rie;
      csrWord[dzPkg::csrRdone]                        = rdone;
      csrWord[dzPkg::csrTlineLo +: dzPkg::lineW]      = tline;
      csrWord[dzPkg::csrTie]                          = tie;
      csrWord[dzPkg::csrTrdy]                         = trdy;
   end

   // Read mux
   always_comb
   begin
      rdData = '0;
      if (csrRead)
         rdData = csrWord;
      else if (rbufRead)
         rdData = rbufWord;
      else if (tcrRead)
         rdData[dzPkg::numLines-1:0] = lineEnable;
   end

   // Level interrupt, either side
   assign intr = (rie && rdone) || (tie && trdy);

   // Host strobes are exclusive
   assert property (@(posedge clk) disable iff (rst) !(read && write))
      else $error("dzRegs: read and write strobes together");

endmodule

`default_nettype wire

// File: dzTxScan.sv
// DZ11 transmit scanner
// Rotates over the lines looking for an enabled, empty transmitter,
// reports TRDY and TLINE and steers a TDR write to that line

`timescale 1ns/1ps
`default_nettype none

module dzTxScan
(
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          init,
   input  wire                          mse,
   input  wire  [dzPkg::numLines-1:0]   lineEnable,
   input  wire  [dzPkg::numLines-1:0]   txEmpty,
   input  wire                          tdrWrite,
   input  wire  [dzPkg::wordW-1:0]      wrData,
   output logic                         trdy,
   output logic [dzPkg::lineW-1:0]      tline,
   output logic [dzPkg::numLines-1:0]   txLoad,
   output logic [7:0]                   txData
);

   logic [dzPkg::lineW-1:0]     ptr;
   logic [dzPkg::numLines-1:0]  ptrHot;
   logic                        lineReady;

   // Line under the pointer can take a character
   assign lineReady = lineEnable[ptr] && txEmpty[ptr];

   ////////////////////
   // Scanner

   always_ff @(posedge clk)
   begin
      if (rst || init)
      begin
         ptr  <= '0;
         trdy <= 1'b0;
      end
      else if (!mse)
         trdy <= 1'b0;
      else if (trdy)
      begin
         // Loaded or line disabled under us
         if (tdrWrite || !lineEnable[ptr])
         begin
            trdy <= 1'b0;
            ptr  <= ptr + 1'b1;
         end
      end
      else if (lineReady)
         trdy <= 1'b1;
      else
         ptr <= ptr + 1'b1;
   end

   // Pointer as a one-hot line select
   always_comb
   begin
      ptrHot      = '0;
      ptrHot[ptr] = 1'b1;
   end

   // TLINE only meaningful with TRDY
   assign tline = trdy ? ptr : '0;

   // TDR write goes to the ready line only
   assign txLoad = (trdy && tdrWrite) ? ptrHot : '0;

   // Character is the low byte of the write
   assign txData = wrData[7:0];

   // Ready line stays idle until the scanner loads it
   assert property (@(posedge clk) disable iff (rst || init) trdy |-> txEmpty[ptr])
      else $error("dzTxScan: ready line not empty");

endmodule

`default_nettype wire

// File: dzUart.sv
// DZ11 serial line
// Fixed 8N1 transmitter and a mid-bit sampling receiver
// Bit time is bitCycles clocks

`timescale 1ns/1ps
`default_nettype none

module dzUart
#(
   parameter int bitCycles = 16
)
(
   input  wire           clk,
   input  wire           rst,
   input  wire           init,
   input  wire           txLoad,
   input  wire  [7:0]    txData,
   input  wire           rxd,
   input  wire           rxClr,
   output logic          txd,
   output logic          txEmpty,
   output logic          rxFull,
   output logic [7:0]    rxData,
   output logic          rxFrme
);

   localparam int cntW = $clog2(bitCycles + 1);
   localparam logic [cntW-1:0] fullBit = cntW'(bitCycles - 1);
   localparam logic [cntW-1:0] halfBit = cntW'(bitCycles / 2 - 1);

   logic [9:0]         txShift;
   logic [cntW-1:0]    txTimer;
   logic [3:0]         txBits;
   logic [2:0]         rxSync;
   logic               rxBit;
   logic               rxFall;
   logic               rxBusy;
   logic [cntW-1:0]    rxTimer;
   logic [3:0]         rxBits;
   logic               rxSample;
   logic [7:0]         rxShift;

   ////////////////////
   // Transmitter

   always_ff @(posedge clk)
   begin
      if (rst || init)
      begin
         txShift <= '1;
         txTimer <= '0;
         txBits  <= '0;
         txEmpty <= 1'b1;
      end
      else if (txLoad)
      begin
         // Stop, data LSB first, start
         txShift <= {1'b1, txData, 1'b0};
         txTimer <= fullBit;
         txBits  <= 4'd10;
         txEmpty <= 1'b0;
      end
      else if (!txEmpty)
      begin
         if (txTimer == '0)
         begin
            // Ones fill behind, so line idles high
            txShift <= {1'b1, txShift[9:1]};
            txTimer <= fullBit;
            txBits  <= txBits - 1'b1;
            if (txBits == 4'd1)
               txEmpty <= 1'b1;
         end
         else
            txTimer <= txTimer - 1'b1;
      end
   end

   assign txd = txShift[0];

   ////////////////////
   // Receiver

   // Two-stage sync plus one stage of history
   always_ff @(posedge clk)
   begin
      if (rst)
         rxSync <= '1;
      else
         rxSync <= {rxSync[1:0], rxd};
   end

   assign rxBit    = rxSync[1];
   assign rxFall   = rxSync[2] && !rxSync[1];
   assign rxSample = rxBusy && (rxTimer == '0);

   // Frame control and full flag
   always_ff @(posedge clk)
   begin
      if (rst || init)
      begin
         rxBusy  <= 1'b0;
         rxTimer <= '0;
         rxBits  <= '0;
         rxFull  <= 1'b0;
      end
      else
      begin
         // Host side clear, a new stop sample below wins
         if (rxClr)
            rxFull <= 1'b0;
         if (!rxBusy)
         begin
            if (rxFall)
            begin
               // Half-bit offset to land mid start bit
               rxBusy  <= 1'b1;
               rxTimer <= halfBit;
               rxBits  <= '0;
            end
         end
         else if (!rxSample)
            rxTimer <= rxTimer - 1'b1;
         else
         begin
            rxTimer <= fullBit;
            rxBits  <= rxBits + 1'b1;
            // Glitch, start bit gone by mid-bit
            if (rxBits == 4'd0 && rxBit)
               rxBusy <= 1'b0;
            else if (rxBits == 4'd9)
            begin
               rxBusy <= 1'b0;
               rxFull <= 1'b1;
            end
         end
      end
   end

   // Data shifter and character output
   always_ff @(posedge clk)
   begin
      if (rxSample)
      begin
         if (rxBits >= 4'd1 && rxBits <= 4'd8)
            rxShift <= {rxBit, rxShift[7:1]};
         if (rxBits == 4'd9)
         begin
            rxData <= rxShift;
            rxFrme <= !rxBit;
         end
      end
   end

   // Scanner only loads an idle transmitter
   assert property (@(posedge clk) disable iff (rst || init) txLoad |-> txEmpty)
      else $error("dzUart: load while transmitter busy");

endmodule

`default_nettype wire

// File: dzRxScan.sv
// DZ11 receive scanner
// Picks one full line at a time into RBUF and clears that line's flag

`timescale 1ns/1ps
`default_nettype none

module dzRxScan
(
   input  wire                               clk,
   input  wire                               rst,
   input  wire                               init,
   input  wire                               mse,
   input  wire  [dzPkg::numLines-1:0]        rxFull,
   input  wire  [dzPkg::numLines-1:0][7:0]   rxData,
   input  wire  [dzPkg::numLines-1:0]        rxFrme,
   input  wire                               rbufRead,
   output logic [dzPkg::wordW-1:0]           rbufWord,
   output logic [dzPkg::numLines-1:0]        rxClr
);

   logic [dzPkg::lineW-1:0]     ptr;
   logic [dzPkg::numLines-1:0]  ptrHot;
   logic                        valid;
   logic                        frme;
   logic [dzPkg::lineW-1:0]     line;
   logic [7:0]                  data;
   logic                        capture;

   // Take the line under the pointer if RBUF is free
   assign capture = mse && !valid && rxFull[ptr];

   always_comb
   begin
      ptrHot      = '0;
      ptrHot[ptr] = 1'b1;
   end

   assign rxClr = capture ? ptrHot : '0;

   ////////////////////
   // RBUF

   always_ff @(posedge clk)
   begin
      if (rst || init)
      begin
         ptr   <= '0;
         valid <= 1'b0;
         frme  <= 1'b0;
         line  <= '0;
         data  <= '0;
      end
      else
      begin
         // Scan only while empty
         if (mse && !valid)
            ptr <= ptr + 1'b1;
         if (capture)
         begin
            valid <= 1'b1;
            frme  <= rxFrme[ptr];
            line  <= ptr;
            data  <= rxData[ptr];
         end
         else if (rbufRead)
            valid <= 1'b0;
      end
   end

   // RBUF word layout
   always_comb
   begin
      rbufWord                                       = '0;
      rbufWord[dzPkg::rbufValid]                     = valid;
      rbufWord[dzPkg::rbufFrme]                      = frme;
      rbufWord[dzPkg::rbufLineLo +: dzPkg::lineW]    = line;
      rbufWord[7:0]                                  = data;
   end

endmodule

`default_nettype wire

// File: dz11.sv
// DZ11 terminal multiplexer, eight 8N1 lines
// Register block, transmit and receive scanners, UART array and
// maintenance loopback

`timescale 1ns/1ps
`default_nettype none

module dz11
#(
   parameter int bitCycles = 16
)
(
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          read,
   input  wire                          write,
   input  wire  [dzPkg::addrW-1:0]      addr,
   input  wire  [dzPkg::wordW-1:0]      wrData,
   input  wire  [dzPkg::numLines-1:0]   rxd,
   output wire  [dzPkg::wordW-1:0]      rdData,
   output wire                          ack,
   output wire  [dzPkg::numLines-1:0]   txd,
   output wire                          intr
);

   wire                               mse;
   wire                               maint;
   wire                               init;
   wire [dzPkg::numLines-1:0]         lineEnable;
   wire                               tdrWrite;
   wire                               rbufRead;
   wire                               trdy;
   wire [dzPkg::lineW-1:0]            tline;
   wire [dzPkg::wordW-1:0]            rbufWord;
   wire [dzPkg::numLines-1:0]         txLoad;
   wire [7:0]                         txData;
   wire [dzPkg::numLines-1:0]         txEmpty;
   wire [dzPkg::numLines-1:0]         rxFull;
   wire [dzPkg::numLines-1:0][7:0]    rxData;
   wire [dzPkg::numLines-1:0]         rxFrme;
   wire [dzPkg::numLines-1:0]         rxClr;
   wire [dzPkg::numLines-1:0]         rxIn;

   // Registers and bus
   dzRegs regs0 (
      .clk(clk), .rst(rst), .read(read), .write(write), .addr(addr),
      .wrData(wrData), .trdy(trdy), .tline(tline), .rbufWord(rbufWord),
      .rdData(rdData), .ack(ack), .mse(mse), .maint(maint), .init(init),
      .lineEnable(lineEnable), .tdrWrite(tdrWrite), .rbufRead(rbufRead),
      .intr(intr)
   );

   // Transmit side
   dzTxScan txScan0 (
      .clk(clk), .rst(rst), .init(init), .mse(mse), .lineEnable(lineEnable),
      .txEmpty(txEmpty), .tdrWrite(tdrWrite), .wrData(wrData),
      .trdy(trdy), .tline(tline), .txLoad(txLoad), .txData(txData)
   );

   // Receive side
   dzRxScan rxScan0 (
      .clk(clk), .rst(rst), .init(init), .mse(mse), .rxFull(rxFull),
      .rxData(rxData), .rxFrme(rxFrme), .rbufRead(rbufRead),
      .rbufWord(rbufWord), .rxClr(rxClr)
   );

   // Maintenance mode loops each transmitter to its own receiver
   assign rxIn = maint ? txd : rxd;

   ////////////////////
   // Line array

   for (genvar i = 0; i < dzPkg::numLines; i++)
   begin : gLine
      dzUart #(
         .bitCycles(bitCycles)
      ) uart0 (
         .clk(clk), .rst(rst), .init(init),
         .txLoad(txLoad[i]), .txData(txData), .rxd(rxIn[i]), .rxClr(rxClr[i]),
         .txd(txd[i]), .txEmpty(txEmpty[i]), .rxFull(rxFull[i]),
         .rxData(rxData[i]), .rxFrme(rxFrme[i])
      );
   end

endmodule

`default_nettype wire

// File: tbDz11.sv
// DZ11 testbench
// Drives the register bus and the serial lines of dz11 through reset,
// register, transmit, loopback, receive and clear tests

`timescale 1ns/1ps
`default_nettype none

module tbDz11;

   localparam int bitCycles = 16;
   // Frames sent or received over all tests
   // Clear test has two of them
   localparam int frameCount = 6;
   localparam int limitCycles = 4 * frameCount * 10 * bitCycles + 2000;

   // CSR bits as host-side masks
   localparam logic [15:0] bMaint = 16'h1 << dzPkg::csrMaint;
   localparam logic [15:0] bClr   = 16'h1 << dzPkg::csrClr;
   localparam logic [15:0] bMse   = 16'h1 << dzPkg::csrMse;
   localparam logic [15:0] bRie   = 16'h1 << dzPkg::csrRie;
   localparam logic [15:0] bTie   = 16'h1 << dzPkg::csrTie;

   logic                          clk;
   logic                          rst;
   logic                          read;
   logic                          write;
   logic [dzPkg::addrW-1:0]       addr;
   logic [15:0]                   wrData;
   logic [7:0]                    rxd;
   wire  [15:0]                   rdData;
   wire                           ack;
   wire  [7:0]                    txd;
   wire                           intr;

   logic [15:0]   lfsr;
   logic [7:0]    quietMask;
   int            errors;
   int            checks;
   int            testsRun;
   int            testsFailed;
   int            errorsBefore;
   logic [2:0]    line;
   logic [2:0]    line2;
   logic [7:0]    data;
   logic [15:0]   word;
   logic [15:0]   value;
   logic [9:0]    frame;

   dz11 #(
      .bitCycles(bitCycles)
   ) dut0 (
      .clk(clk), .rst(rst), .read(read), .write(write), .addr(addr),
      .wrData(wrData), .rxd(rxd), .rdData(rdData), .ack(ack), .txd(txd),
      .intr(intr)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////
   // Helpers

   // 16-bit Fibonacci LFSR with taps 16 14 13 11
   // One step per bit
   function automatic logic [15:0] randBits(input int n);
      logic [15:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         v    = {v[14:0], fb};
      end
      return v;
   endfunction

   task automatic checkEq(input string name, input logic [15:0] expVal,
                          input logic [15:0] actVal);
      checks++;
      assert (actVal === expVal)
      else
      begin
         $display("[FAIL] %s expected %h actual %h", name, expVal, actVal);
         errors++;
      end
   endtask

   // One-cycle write strobe that lands at the closing edge
   task automatic writeReg(input logic [dzPkg::addrW-1:0] a, input logic [15:0] d);
      @(posedge clk);
      write  <= 1'b1;
      addr   <= a;
      wrData <= d;
      @(posedge clk);
      write  <= 1'b0;
   endtask

   // Read data sampled mid-cycle
   task automatic readReg(input logic [dzPkg::addrW-1:0] a, output logic [15:0] d);
      @(posedge clk);
      read <= 1'b1;
      addr <= a;
      @(negedge clk);
      d = rdData;
      @(posedge clk);
      read <= 1'b0;
   endtask

   // Poll CSR until a status bit comes up
   task automatic waitCsrBit(input int pos, input string name, output logic [15:0] w);
      int polls;
      polls = 0;
      readReg(dzPkg::offCsr, w);
      while (!w[pos] && polls < 500)
      begin
         readReg(dzPkg::offCsr, w);
         polls++;
      end
      if (!w[pos])
      begin
         $display("%s: CSR bit %0d never came up", name, pos);
         errors++;
      end
   endtask

   // Host side line driven LSB first at bitCycles per bit
   task automatic sendFrame(input logic [2:0] ln, input logic [7:0] d, input logic stopBit);
      logic [9:0] f;
      f = {stopBit, d, 1'b0};
      for (int i = 0; i < 10; i++)
      begin
         @(posedge clk);
         rxd[ln] <= f[i];
         repeat (bitCycles - 1) @(posedge clk);
      end
      @(posedge clk);
      rxd[ln] <= 1'b1;
   endtask

   // Mid-bit sampling of one txd frame with the start bit in f[0]
   task automatic decodeFrame(input logic [2:0] ln, output logic [9:0] f);
      wait (txd[ln] === 1'b0);
      repeat (bitCycles / 2) @(negedge clk);
      for (int i = 0; i < 10; i++)
      begin
         f[i] = txd[ln];
         if (i < 9)
            repeat (bitCycles) @(negedge clk);
      end
   endtask

   task automatic endTest(input string name);
      testsRun++;
      if (errors == errorsBefore)
         $display("test %-9s ok", name);
      else
      begin
         testsFailed++;
         $display("test %-9s bad, %0d errors", name, errors - errorsBefore);
      end
      errorsBefore = errors;
   endtask

   ////////////////////
   // Bus and line checks

   // Every host access hits a defined register
   assert property (@(posedge clk) disable iff (rst) (read || write) |-> ack)
   else
   begin
      $display("bus access at offset %0d was not acknowledged", addr);
      errors++;
   end

   // Only the line under test may leave idle
   assert property (@(posedge clk) disable iff (rst) &(txd | ~quietMask))
   else
   begin
      $display("[FAIL] idle lines expected %b actual %b", quietMask, txd & quietMask);
      errors++;
   end

   // Watchdog
   initial
   begin
      repeat (limitCycles) @(posedge clk);
      $display("watchdog: run did not finish within %0d cycles", limitCycles);
      $display("TEST FAILED");
      $finish;
   end

   ////////////////////
   // Tests

   initial
   begin
      rst = 1'b1;
      read = 1'b0;
      write = 1'b0;
      addr = '0;
      wrData = '0;
      rxd = '1;
      quietMask = '1;
      lfsr = 16'd42;
      errors = 0;
      checks = 0;
      testsRun = 0;
      testsFailed = 0;
      errorsBefore = 0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;

      // Reset state
      readReg(dzPkg::offCsr, word);
      checkEq("reset csr", 16'h0, word);
      readReg(dzPkg::offTcr, word);
      checkEq("reset tcr", 16'h0, word);
      readReg(dzPkg::offRbuf, word);
      checkEq("reset rbuf valid", 16'h0, 16'(word[dzPkg::rbufValid]));
      @(negedge clk);
      checkEq("reset intr", 16'h0, 16'(intr));
      checkEq("reset txd", 16'h00FF, 16'(txd));
      endTest("reset");

      // Register access with mse low keeps only writable bits
      value = randBits(16);
      writeReg(dzPkg::offTcr, value);
      readReg(dzPkg::offTcr, word);
      checkEq("regs tcr", value & 16'h00FF, word);
      value = randBits(16) & ~(bClr | bMse);
      writeReg(dzPkg::offCsr, value);
      readReg(dzPkg::offCsr, word);
      checkEq("regs csr", value & (bMaint | bRie | bTie), word);
      endTest("regs");

      // Transmit on one random line
      line = 3'(randBits(3));
      data = 8'(randBits(8));
      writeReg(dzPkg::offTcr, 16'h1 << line);
      writeReg(dzPkg::offCsr, bMse | bTie);
      waitCsrBit(dzPkg::csrTrdy, "transmit", word);
      checkEq("transmit tline", 16'(line), 16'(word[10:8]));
      @(negedge clk);
      checkEq("transmit intr", 16'h1, 16'(intr));
      quietMask = ~(8'h1 << line);
      fork
         decodeFrame(line, frame);
         begin
            writeReg(dzPkg::offTdr, 16'(data));
            readReg(dzPkg::offCsr, word);
            checkEq("transmit trdy", 16'h0, 16'(word[dzPkg::csrTrdy]));
         end
      join
      checkEq("transmit frame", 16'({1'b1, data, 1'b0}), 16'(frame));
      quietMask = '1;
      endTest("transmit");

      // Maintenance loopback
      line = 3'(randBits(3));
      data = 8'(randBits(8));
      writeReg(dzPkg::offTcr, 16'h1 << line);
      writeReg(dzPkg::offCsr, bMse | bMaint | bRie);
      waitCsrBit(dzPkg::csrTrdy, "loopback", word);
      checkEq("loopback tline", 16'(line), 16'(word[10:8]));
      quietMask = ~(8'h1 << line);
      writeReg(dzPkg::offTdr, 16'(data));
      waitCsrBit(dzPkg::csrRdone, "loopback", word);
      @(negedge clk);
      checkEq("loopback intr", 16'h1, 16'(intr));
      readReg(dzPkg::offRbuf, word);
      checkEq("loopback rbuf", 16'h8000 | (16'(line) << 8) | 16'(data), word);
      readReg(dzPkg::offRbuf, word);
      checkEq("loopback reread", 16'h0, 16'(word[dzPkg::rbufValid]));
      quietMask = '1;
      endTest("loopback");

      // External receive of a good frame then a framing error
      writeReg(dzPkg::offCsr, bMse | bRie);
      line = 3'(randBits(3));
      data = 8'(randBits(8));
      sendFrame(line, data, 1'b1);
      waitCsrBit(dzPkg::csrRdone, "receive", word);
      readReg(dzPkg::offRbuf, word);
      checkEq("receive rbuf", 16'h8000 | (16'(line) << 8) | 16'(data), word);
      line = 3'(randBits(3));
      data = 8'(randBits(8));
      sendFrame(line, data, 1'b0);
      waitCsrBit(dzPkg::csrRdone, "receive", word);
      readReg(dzPkg::offRbuf, word);
      checkEq("receive frme", 16'hA000 | (16'(line) << 8) | 16'(data), word);
      endTest("receive");

      // Clear during the start bit of a transmit with RBUF full
      line = 3'(randBits(3));
      line2 = 3'(randBits(3));
      data = 8'(randBits(8));
      writeReg(dzPkg::offTcr, 16'h1 << line);
      writeReg(dzPkg::offCsr, bMse | bRie | bTie);
      sendFrame(line2, data, 1'b1);
      waitCsrBit(dzPkg::csrRdone, "clear", word);
      waitCsrBit(dzPkg::csrTrdy, "clear", word);
      quietMask = ~(8'h1 << line);
      writeReg(dzPkg::offTdr, 16'(data));
      repeat (bitCycles / 2) @(posedge clk);
      writeReg(dzPkg::offCsr, bClr);
      @(posedge clk);
      @(negedge clk);
      checkEq("clear txd", 16'h00FF, 16'(txd));
      checkEq("clear intr", 16'h0, 16'(intr));
      quietMask = '1;
      readReg(dzPkg::offCsr, word);
      checkEq("clear csr", 16'h0, word);
      readReg(dzPkg::offTcr, word);
      checkEq("clear tcr", 16'h0, word);
      readReg(dzPkg::offRbuf, word);
      checkEq("clear rbuf", 16'h0, word);
      endTest("clear");

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               testsRun, testsFailed, checks, errors);
      if (errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
dzPkg.sv
dzRegs.sv
dzTxScan.sv
dzUart.sv
dzRxScan.sv
dz11.sv
tbDz11.sv

// File: Makefile
# Verilator flow for the DZ11 multiplexer
TOP = tbDz11

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

sim: lint
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o simDz11
	./obj_dir/simDz11 > sim.log 2>&1 || true
	cat sim.log
	! grep -q "TEST FAILED" sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
